//--- life_top.f
+incdir+hw
hw/life_grid_pkg.sv
hw/life_ctrl_pkg.sv
hw/button_debounce.sv
hw/grid_seeder.sv
hw/generation_sequencer.sv
hw/cell_ram.sv
hw/life_engine.sv
hw/life_top.sv
verif/life_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the life testbench with Verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f life_top.f --top-module life_tb \
	--Mdir obj_dir -o life_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/life_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- verif/life_stimulus.txt
# columns: command, then its number
# press/hold take cycles held, bounce takes glitch count, expect_gen takes count step
# seed grid straight after init
read
# glitches leave count and grid alone
bounce 6
expect_gen 0
read
# one press, rows read while the generation runs
press 30
read
expect_gen 1
read
# a single short glitch
bounce 1
expect_gen 0
read
press 40
expect_gen 1
read
# long hold chains generations until the release debounce ends
hold 400
expect_gen 9
read
press 25
read
expect_gen 1
read

//--- verif/life_tb.sv
////////////////////////////////////////
// reads verif/life_stimulus.txt, so run from the project root
// model history holds at most 32 generations past the seed grid
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module life_tb
	import life_grid_pkg::*;
;

	localparam int D = `LIFE_DEPTH;
	localparam int W = `LIFE_WIDTH;
	localparam int MAX_GEN = 32;
	// busy low this long means the button FSM is back in idle
	localparam int QUIET_CYCLES = `DEBOUNCE_PRESS_CYCLES + `DEBOUNCE_PULSE_CYCLES +
		`DEBOUNCE_RELEASE_CYCLES + 20;
	// worst case generation, one stall per window read
	localparam int GEN_CYCLES = 2 * D + `LIFE_WRITE_DELAY + 4;

	logic clk;
	logic reset;
	logic fire_button;
	logic row_req;
	row_addr_t row_addr;
	cell_row_t row_data;
	logic row_valid;
	gen_count_t gen_count;
	logic busy;
	logic init_done;

	int value_errors;
	int other_errors;
	int cycle_count;
	int cycle_limit;
	gen_count_t expected_gen;
	// count and busy as seen one cycle earlier
	gen_count_t prev_gen;
	logic prev_busy;
	string cmd_q[$];
	int arg_q[$];
	// model grid of every generation, index 0 is the seed grid
	cell_row_t hist [0:MAX_GEN][0:`LIFE_DEPTH-1];

	life_top dut_i (
		.clk(clk),
		.reset(reset),
		.fire_button(fire_button),
		.row_req(row_req),
		.row_addr(row_addr),
		.row_data(row_data),
		.row_valid(row_valid),
		.gen_count(gen_count),
		.busy(busy),
		.init_done(init_done)
	);

	always #4 clk = ~clk;

	// run limit, armed from the command list at time 0
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, run did not finish", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_row(input string name, input cell_row_t got, input cell_row_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_gen(input string name, input gen_count_t got, input gen_count_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// busy falls only together with a count step
	// each step is one generation and happens while busy
	always @(negedge clk) begin
		if (reset === 1'b0) begin
			if (prev_busy === 1'b1 && busy === 1'b0) begin
				check_gen("gen_count", gen_count, prev_gen + 1'b1);
			end else if (gen_count !== prev_gen) begin
				check_gen("gen_count", gen_count, prev_gen + 1'b1);
				check_bit("busy", prev_busy, 1'b1);
			end
		end
		prev_gen = gen_count;
		prev_busy = busy;
	end

	////////////////////////////////////////
	// reference models
	////////////////////////////////////////
	// right shifting galois lfsr, row k gets k+1 steps
	task automatic build_seed_grid();
		logic [31:0] state;
		state = `LFSR_SEED;
		for (int r = 0; r < D; r++) begin
			if (state[0])
				state = (state >> 1) ^ `LFSR_TAPS;
			else
				state = state >> 1;
			hist[0][r] = cell_row_t'(state);
		end
	endtask

	// toroidal life, nine cell sum including the centre
	task automatic step_model(input int g);
		int sum;
		for (int r = 0; r < D; r++) begin
			for (int c = 0; c < W; c++) begin
				sum = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if (hist[g][(r + dr + D) % D][(c + dc + W) % W])
							sum++;
					end
				end
				hist[g + 1][r][c] = (sum == 3) || ((sum == 4) && hist[g][r][c]);
			end
		end
	endtask

	////////////////////////////////////////
	// stimulus file and commands
	////////////////////////////////////////
	task automatic load_commands();
		int fd;
		int arg;
		int ch;
		string cmd;
		fd = $fopen("verif/life_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open verif/life_stimulus.txt");
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				if (cmd[0] == "#") begin
					// skip the rest of a comment line
					ch = 0;
					while (ch != 10 && ch != -1)
						ch = $fgetc(fd);
				end else if (cmd == "read") begin
					cmd_q.push_back(cmd);
					arg_q.push_back(0);
				end else if ($fscanf(fd, "%d", arg) == 1) begin
					cmd_q.push_back(cmd);
					arg_q.push_back(arg);
				end else begin
					other_errors++;
					$display("command %s has no number after it", cmd);
				end
			end
			$fclose(fd);
		end
	endtask

	// upper bound on the cycles one command can take
	function automatic int command_cycles(input string cmd, input int arg);
		if (cmd == "bounce")
			return arg * (`DEBOUNCE_PRESS_CYCLES / 2 + 12);
		if (cmd == "read")
			return D * 12;
		if (cmd == "expect_gen")
			return QUIET_CYCLES + (arg + 1) * GEN_CYCLES;
		return arg + 2;
	endfunction

	task automatic press_button(input int n);
		@(posedge clk);
		fire_button <= 1'b1;
		repeat (n) @(posedge clk);
		fire_button <= 1'b0;
	endtask

	// n glitches, each shorter than the press time
	task automatic bounce_button(input int n);
		int width;
		int gap;
		for (int i = 0; i < n; i++) begin
			width = int'($urandom_range(`DEBOUNCE_PRESS_CYCLES / 2, 1));
			gap = int'($urandom_range(8, 2));
			@(posedge clk);
			fire_button <= 1'b1;
			repeat (width) @(posedge clk);
			fire_button <= 1'b0;
			repeat (gap) @(posedge clk);
		end
	endtask

	// one request per row at random gaps
	// expected row is from the generation current at the request
	task automatic read_all_rows();
		int gap;
		gen_count_t req_gen;
		for (int r = 0; r < D; r++) begin
			gap = int'($urandom_range(3, 0));
			repeat (gap) @(posedge clk);
			@(posedge clk);
			row_req <= 1'b1;
			row_addr <= row_addr_t'(r);
			@(negedge clk);
			req_gen = gen_count;
			@(posedge clk);
			row_req <= 1'b0;
			@(negedge clk);
			check_bit("row_valid", row_valid, 1'b0);
			@(negedge clk);
			check_bit("row_valid", row_valid, 1'b0);
			@(negedge clk);
			check_bit("row_valid", row_valid, 1'b1);
			// at most one generation can finish ahead of the next count check
			if (req_gen < expected_gen || req_gen > expected_gen + 1'b1 ||
					req_gen > gen_count_t'(MAX_GEN)) begin
				other_errors++;
				$display("row %0d was read in generation %0d, outside the expected range",
					r, req_gen);
			end else begin
				check_row($sformatf("row_data (row %0d)", r), row_data, hist[int'(req_gen)][r]);
			end
		end
	endtask

	// wait for the FSMs to go quiet, then compare the count step
	task automatic expect_generations(input int k);
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk);
			quiet = busy ? 0 : quiet + 1;
		end
		expected_gen = expected_gen + gen_count_t'(k);
		check_gen("gen_count", gen_count, expected_gen);
	endtask

	task automatic run_command(input string cmd, input int arg);
		if (cmd == "press" || cmd == "hold") begin
			press_button(arg);
		end else if (cmd == "bounce") begin
			bounce_button(arg);
		end else if (cmd == "read") begin
			read_all_rows();
		end else if (cmd == "expect_gen") begin
			expect_generations(arg);
		end else begin
			other_errors++;
			$display("unknown command %s in stimulus file", cmd);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		fire_button = 1'b0;
		row_req = 1'b0;
		row_addr = '0;
		value_errors = 0;
		other_errors = 0;
		cycle_count = 0;
		expected_gen = '0;
		prev_gen = '0;
		prev_busy = 1'b0;
		void'($urandom(32'ha684_72ef));
		load_commands();
		cycle_limit = 16 + `INIT_WAIT_CYCLES + D + 500;
		for (int i = 0; i < cmd_q.size(); i++)
			cycle_limit = cycle_limit + command_cycles(cmd_q[i], arg_q[i]);
		build_seed_grid();
		for (int g = 0; g < MAX_GEN; g++)
			step_model(g);

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("row_valid", row_valid, 1'b0);
		check_bit("init_done", init_done, 1'b0);
		check_gen("gen_count", gen_count, '0);

		// seeder runs on its own after reset
		while (init_done !== 1'b1)
			@(negedge clk);

		for (int i = 0; i < cmd_q.size(); i++)
			run_command(cmd_q[i], arg_q[i]);

		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/life_top.sv
////////////////////////////////////////
// single clock, reset synchronous and active high
////////////////////////////////////////
`default_nettype none

module life_top
	import life_grid_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic fire_button,
	input  logic row_req,
	input  row_addr_t row_addr,
	output cell_row_t row_data,
	output logic row_valid,
	output gen_count_t gen_count,
	output logic busy,
	output logic init_done
);

	// button to sequencer
	logic press_pulse;
	logic hold;

	// seeder to engine
	logic seed_we;
	row_addr_t seed_addr;
	cell_row_t seed_row;

	// sequencer to engine
	row_addr_t rd_addr;
	logic rd_bank;
	logic shift_en;
	logic ld;
	logic swap;
	slot_tag_t slot_tag;

	button_debounce button_debounce_i (
		.clk(clk),
		.reset(reset),
		.button(fire_button),
		.press_pulse(press_pulse),
		.hold(hold)
	);

	grid_seeder grid_seeder_i (
		.clk(clk),
		.reset(reset),
		.seed_we(seed_we),
		.seed_addr(seed_addr),
		.seed_row(seed_row),
		.init_done(init_done)
	);

	generation_sequencer generation_sequencer_i (
		.clk(clk),
		.reset(reset),
		.press_pulse(press_pulse),
		.hold(hold),
		.init_done(init_done),
		.row_req(row_req),
		.row_addr(row_addr),
		.rd_addr(rd_addr),
		.rd_bank(rd_bank),
		.shift_en(shift_en),
		.ld(ld),
		.swap(swap),
		.busy(busy),
		.slot_tag(slot_tag),
		.gen_count(gen_count)
	);

	life_engine life_engine_i (
		.clk(clk),
		.reset(reset),
		.rd_addr(rd_addr),
		.rd_bank(rd_bank),
		.shift_en(shift_en),
		.ld(ld),
		.swap(swap),
		.slot_tag(slot_tag),
		.seed_we(seed_we),
		.seed_addr(seed_addr),
		.seed_row(seed_row),
		.row_data(row_data),
		.row_valid(row_valid)
	);

endmodule

`default_nettype wire

//--- hw/life_engine.sv
////////////////////////////////////////
// seeder and generation writes must never overlap
// window reads from the current bank, results go to the other
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module life_engine
	import life_grid_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  row_addr_t rd_addr,
	input  logic rd_bank,
	input  logic shift_en,
	input  logic ld,
	input  logic swap,
	input  slot_tag_t slot_tag,
	input  logic seed_we,
	input  row_addr_t seed_addr,
	input  cell_row_t seed_row,
	output cell_row_t row_data,
	output logic row_valid
);

	localparam int W = `LIFE_WIDTH;
	localparam int WD = `LIFE_WRITE_DELAY;

	logic bank;
	logic [WD:1] sh_d;
	slot_tag_t [WD:1] tag_d;
	logic [2:1] ld_d;
	cell_row_t rd_data;
	// [0] newest row, [1] centre, [2] oldest
	cell_row_t [2:0] win;
	logic [W-1:0][1:0] add3;
	logic [W-1:0][1:0] add3_q;
	cell_row_t center_q;
	logic [W-1:0][3:0] add9;
	cell_row_t next_row;
	cell_row_t result_q;
	logic wr_en;

	cell_ram cell_ram_i (
		.clk(clk),
		.wr_en(wr_en),
		.wr_bank(seed_we ? 1'b0 : ~bank),
		.wr_addr(seed_we ? seed_addr : tag_d[WD].dest),
		.wr_data(seed_we ? seed_row : result_q),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	assign wr_en = seed_we || (sh_d[WD] && tag_d[WD].compute);

	// control pipe, tags follow their own shift slot
	always_ff @(posedge clk) begin
		if (reset) begin
			bank <= 1'b0;
			sh_d <= '0;
			ld_d <= '0;
			row_valid <= 1'b0;
		end else begin
			if (swap)
				bank <= ~bank;
			sh_d <= {sh_d[WD-1:1], shift_en};
			ld_d <= {ld_d[1], ld};
			row_valid <= ld_d[2];
		end
	end

	always_ff @(posedge clk) begin
		if (shift_en)
			tag_d[1] <= slot_tag;
		for (int k = 2; k <= WD; k++) begin
			if (sh_d[k-1])
				tag_d[k] <= tag_d[k-1];
		end
		// readout latch, held until the next request
		if (ld_d[2])
			row_data <= rd_data;
	end

	////////////////////////////////////////
	// window, sums and rule
	////////////////////////////////////////
	always_comb begin
		for (int ii = 0; ii < W; ii++) begin
			add3[ii] = {1'b0, win[2][ii]} + {1'b0, win[1][ii]} + {1'b0, win[0][ii]};
		end
		// horizontal neighbours wrap around the row ends
		for (int ii = 0; ii < W; ii++) begin
			add9[ii] = {2'b00, add3_q[(ii + W - 1) % W]} + {2'b00, add3_q[ii]} +
				{2'b00, add3_q[(ii + 1) % W]};
			next_row[ii] = (add9[ii] == 4'd3) || ((add9[ii] == 4'd4) && center_q[ii]);
		end
	end

	always_ff @(posedge clk) begin
		if (sh_d[2])
			win <= {win[1:0], rd_data};
		if (sh_d[3]) begin
			add3_q <= add3;
			center_q <= win[1];
		end
		if (sh_d[4])
			result_q <= next_row;
	end

endmodule

`default_nettype wire

//--- hw/cell_ram.sv
////////////////////////////////////////
// two banks of depth rows, two cycle read
// read of a row written the cycle before returns the new data
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module cell_ram
	import life_grid_pkg::*;
(
	input  logic clk,
	input  logic wr_en,
	input  logic wr_bank,
	input  row_addr_t wr_addr,
	input  cell_row_t wr_data,
	input  logic rd_bank,
	input  row_addr_t rd_addr,
	output cell_row_t rd_data
);

	// bank bit on top of the row index
	cell_row_t mem [0:2*`LIFE_DEPTH-1];
	logic [`LIFE_ADDR_BITS:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_bank, wr_addr}] <= wr_data;
	end

	// address register, then output register
	always_ff @(posedge clk) begin
		rd_ptr <= {rd_bank, rd_addr};
		rd_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

//--- hw/generation_sequencer.sv
////////////////////////////////////////
// row_req always wins its cycle and stalls the window walk
// a press during a running generation is dropped
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module generation_sequencer
	import life_grid_pkg::*;
	import life_ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic press_pulse,
	input  logic hold,
	input  logic init_done,
	input  logic row_req,
	input  row_addr_t row_addr,
	output row_addr_t rd_addr,
	output logic rd_bank,
	output logic shift_en,
	output logic ld,
	output logic swap,
	output logic busy,
	output slot_tag_t slot_tag,
	output gen_count_t gen_count
);

	localparam int CNT_BITS = $clog2(`LIFE_DEPTH + `LIFE_WRITE_DELAY + 2);
	// reads 0 .. depth+1, rows depth-1, 0 .. depth-1, 0
	localparam logic [CNT_BITS-1:0] LAST_READ = CNT_BITS'(`LIFE_DEPTH + 1);
	// cycle in which the final write lands
	localparam logic [CNT_BITS-1:0] SWAP_AT = CNT_BITS'(`LIFE_DEPTH + 1 + `LIFE_WRITE_DELAY);
	localparam logic [CNT_BITS-1:0] FIRST_TAGGED = CNT_BITS'(2);

	seq_state_e state;
	logic [CNT_BITS-1:0] cnt;
	logic bank;
	logic reading;

	assign reading = (state == seq_run) && (cnt <= LAST_READ);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_wait_init;
			cnt <= '0;
			bank <= 1'b0;
			gen_count <= '0;
		end else begin
			case (state)
				seq_wait_init:
					if (init_done)
						state <= seq_idle;
				seq_idle:
					if (press_pulse || hold) begin
						state <= seq_run;
						cnt <= '0;
					end
				seq_run:
					if (cnt == SWAP_AT) begin
						bank <= ~bank;
						gen_count <= gen_count + 1'b1;
						cnt <= '0;
						// held button chains straight into the next one
						if (!hold)
							state <= seq_idle;
					end else if (!reading || !row_req) begin
						// drain cycles never stall
						cnt <= cnt + 1'b1;
					end
				default:
					state <= seq_wait_init;
			endcase
		end
	end

	////////////////////////////////////////
	// read slot outputs
	////////////////////////////////////////
	assign ld = row_req;
	assign shift_en = reading && !row_req;
	assign rd_addr = row_req ? row_addr : row_addr_t'(cnt[`LIFE_ADDR_BITS-1:0] - 1'b1);
	assign rd_bank = bank;

	// window centre sits one row behind the newest read
	assign slot_tag.compute = (cnt >= FIRST_TAGGED);
	assign slot_tag.dest = row_addr_t'(cnt[`LIFE_ADDR_BITS-1:0] - 2'd2);

	assign swap = (state == seq_run) && (cnt == SWAP_AT);
	assign busy = (state == seq_run);

endmodule

`default_nettype wire

//--- hw/grid_seeder.sv
////////////////////////////////////////
// seeds bank 0 once after reset, then stays quiet
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module grid_seeder
	import life_grid_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic seed_we,
	output row_addr_t seed_addr,
	output cell_row_t seed_row,
	output logic init_done
);

	localparam int LAST = `INIT_WAIT_CYCLES + `LIFE_DEPTH;
	localparam int CNT_BITS = $clog2(LAST + 1);
	localparam logic [CNT_BITS-1:0] WRITE_START = CNT_BITS'(`INIT_WAIT_CYCLES);
	localparam logic [CNT_BITS-1:0] WRITE_END = CNT_BITS'(LAST);

	logic [CNT_BITS-1:0] cnt;
	logic [31:0] lfsr;

	// lfsr steps from one cycle before the first write
	// so row k sees k+1 steps
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			lfsr <= `LFSR_SEED;
		end else begin
			if (cnt != WRITE_END)
				cnt <= cnt + 1'b1;
			if (cnt >= WRITE_START - 1'b1 && cnt < WRITE_END - 1'b1)
				lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? `LFSR_TAPS : 32'h0);
		end
	end

	// one row per cycle in the write window
	assign seed_we = (cnt >= WRITE_START) && (cnt < WRITE_END);
	assign seed_addr = row_addr_t'(cnt - WRITE_START);
	assign seed_row = lfsr;

	// terminal count holds forever
	assign init_done = (cnt == WRITE_END);

endmodule

`default_nettype wire

//--- hw/button_debounce.sv
////////////////////////////////////////
// raw async button in, one press pulse per clean press
// hold stays high while a long press lasts plus release debounce
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

module button_debounce
	import life_ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic press_pulse,
	output logic hold
);

	localparam int PRESS_BITS = $clog2(`DEBOUNCE_LONG_CYCLES + 1);
	localparam int REL_BITS = $clog2(`DEBOUNCE_RELEASE_CYCLES + 1);

	logic [2:0] sync;
	logic btn;
	button_state_e state;
	logic [PRESS_BITS-1:0] press_cnt;
	logic [REL_BITS-1:0] release_cnt;

	// three flop synchronizer
	always_ff @(posedge clk) begin
		sync <= {sync[1:0], button};
	end
	assign btn = sync[2];

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= btn_idle;
		end else begin
			case (state)
				btn_idle:
					state <= btn ? btn_wait_press : btn_idle;
				btn_wait_press:
					// glitch shorter than the press time falls back
					state <= !btn ? btn_idle :
						(press_cnt == `DEBOUNCE_PRESS_CYCLES) ? btn_wait_pulse : btn_wait_press;
				btn_wait_pulse:
					state <= (press_cnt == `DEBOUNCE_PULSE_CYCLES) ? btn_wait_long : btn_wait_pulse;
				btn_wait_long:
					state <= !btn ? btn_wait_off :
						(press_cnt >= `DEBOUNCE_LONG_CYCLES) ? btn_long : btn_wait_long;
				btn_long:
					state <= !btn ? btn_wait_long_off : btn_long;
				btn_wait_off:
					state <= btn ? btn_wait_long :
						(release_cnt == `DEBOUNCE_RELEASE_CYCLES) ? btn_idle : btn_wait_off;
				btn_wait_long_off:
					state <= btn ? btn_long :
						(release_cnt == `DEBOUNCE_RELEASE_CYCLES) ? btn_idle : btn_wait_long_off;
				default:
					state <= btn_idle;
			endcase
		end
	end

	// counters, press one saturates at the long threshold
	always_ff @(posedge clk) begin
		if (reset) begin
			press_cnt <= '0;
			release_cnt <= '0;
		end else begin
			if (state == btn_idle)
				press_cnt <= '0;
			else if (press_cnt != `DEBOUNCE_LONG_CYCLES)
				press_cnt <= press_cnt + 1'b1;
			if (state == btn_wait_off || state == btn_wait_long_off)
				release_cnt <= release_cnt + 1'b1;
			else
				release_cnt <= '0;
		end
	end

	// single cycle, coincides with entry to wait_pulse
	always_ff @(posedge clk) begin
		if (reset)
			press_pulse <= 1'b0;
		else
			press_pulse <= (state == btn_wait_press) && btn &&
				(press_cnt == `DEBOUNCE_PRESS_CYCLES);
	end

	assign hold = (state == btn_long) || (state == btn_wait_long_off);

endmodule

`default_nettype wire

//--- hw/life_ctrl_pkg.sv
////////////////////////////////////////
// state encodings for the control FSMs
////////////////////////////////////////
`default_nettype none

package life_ctrl_pkg;

	// fire button debounce FSM
	typedef enum logic [2:0] {
		btn_idle,
		btn_wait_press,
		btn_wait_pulse,
		btn_wait_long,
		btn_long,
		btn_wait_off,
		btn_wait_long_off
	} button_state_e;

	// generation sequencer FSM
	typedef enum logic [1:0] {
		seq_wait_init,
		seq_idle,
		seq_run
	} seq_state_e;

endpackage

`default_nettype wire

//--- hw/life_grid_pkg.sv
////////////////////////////////////////
// grid data types, sized from the config header
////////////////////////////////////////
`default_nettype none

`include "life_config.svh"

package life_grid_pkg;

	// one full row of cells, bit n is column n
	typedef logic [`LIFE_WIDTH-1:0] cell_row_t;

	// row index into one bank
	typedef logic [`LIFE_ADDR_BITS-1:0] row_addr_t;

	// finished generations since reset
	typedef logic [`LIFE_GEN_BITS-1:0] gen_count_t;

	// travels with every window read down the engine pipe
	// compute clear for the two priming reads
	typedef struct packed {
		logic      compute;
		row_addr_t dest;
	} slot_tag_t;

endpackage

`default_nettype wire

//--- hw/life_config.svh
////////////////////////////////////////
// grid depth must be a power of two and equal 2**LIFE_ADDR_BITS
// row width must match the 32-bit seed LFSR
////////////////////////////////////////
`ifndef LIFE_CONFIG_SVH
`define LIFE_CONFIG_SVH

// grid geometry
`define LIFE_WIDTH 32
`define LIFE_DEPTH 32
`define LIFE_ADDR_BITS 5

// generation counter width
`define LIFE_GEN_BITS 32

// engine write trails its window read by this many cycles
// fixed by the engine stage structure
`define LIFE_WRITE_DELAY 5

// galois lfsr, taps 32 22 2 1, shifting right
`define LFSR_SEED 32'hACE1_2B67
`define LFSR_TAPS 32'h8020_0003

// idle cycles after reset before the grid is seeded
`define INIT_WAIT_CYCLES 64

// fire button timing, simulation scale
`define DEBOUNCE_PRESS_CYCLES 20
`define DEBOUNCE_PULSE_CYCLES 80
`define DEBOUNCE_LONG_CYCLES 300
`define DEBOUNCE_RELEASE_CYCLES 200

`endif
